// ==== logic/k16_isa_pkg.sv ====
package k16_isa_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_idx_t;

  // Major opcodes in bits 15..13
  localparam logic [2:0] op_alu      = 3'd0;
  localparam logic [2:0] op_shift    = 3'd1;
  localparam logic [2:0] op_branch   = 3'd2;
  localparam logic [2:0] op_load_imm = 3'd3;
  localparam logic [2:0] op_jmp      = 3'd4;
  localparam logic [2:0] op_jsr      = 3'd5;
  localparam logic [2:0] op_ld       = 3'd6;
  localparam logic [2:0] op_sto      = 3'd7;

  // Sub-functions of the ALU group in bits 3..0
  localparam logic [3:0] sub_inc = 4'b1100;
  localparam logic [3:0] sub_cmp = 4'b1110;
  localparam logic [3:0] sub_dec = 4'b1111;

  localparam word_t halt_word = 16'h9fff;

  localparam logic [2:0] cls_arith = 3'd0;
  localparam logic [2:0] cls_shift = 3'd1;
  localparam logic [2:0] cls_byte  = 3'd2;

  localparam logic [2:0] fn_add = 3'd0;
  localparam logic [2:0] fn_adc = 3'd1;
  localparam logic [2:0] fn_sub = 3'd2;
  localparam logic [2:0] fn_sbc = 3'd3;
  localparam logic [2:0] fn_and = 3'd4;
  localparam logic [2:0] fn_or  = 3'd5;
  localparam logic [2:0] fn_xor = 3'd6;
  localparam logic [2:0] fn_not = 3'd7;

  localparam logic [2:0] fn_shr  = 3'd0;
  localparam logic [2:0] fn_shl  = 3'd1;
  localparam logic [2:0] fn_ashr = 3'd2;
  localparam logic [2:0] fn_ror  = 3'd3;
  localparam logic [2:0] fn_rol  = 3'd4;

  localparam logic [2:0] fn_ldl  = 3'd0;
  localparam logic [2:0] fn_ldh  = 3'd1;
  localparam logic [2:0] fn_ldlz = 3'd2;
  localparam logic [2:0] fn_ldhz = 3'd3;

  // Branch conditions in bits 12..10
  localparam logic [2:0] cond_cs = 3'd0;
  localparam logic [2:0] cond_cc = 3'd1;
  localparam logic [2:0] cond_zs = 3'd2;
  localparam logic [2:0] cond_zc = 3'd3;
  localparam logic [2:0] cond_ns = 3'd4;
  localparam logic [2:0] cond_nc = 3'd5;
  localparam logic [2:0] cond_os = 3'd6;
  localparam logic [2:0] cond_oc = 3'd7;

  typedef struct packed {
    logic [2:0] major;
    reg_idx_t   dest;
    reg_idx_t   src_a;
    reg_idx_t   src_b;
    logic [3:0] func;
  } reg_form_t;

  typedef struct packed {
    logic [2:0] major;
    reg_idx_t   dest;
    reg_idx_t   base;
    logic [6:0] offset;
  } mem_form_t;

  typedef struct packed {
    logic [2:0] major;
    reg_idx_t   dest;
    logic [1:0] mode;
    logic [7:0] imm;
  } imm_form_t;

  typedef union packed {
    reg_form_t reg_form;
    mem_form_t mem_form;
    imm_form_t imm_form;
  } k16_instr_u;

endpackage

// ==== logic/k16_cpu_pkg.sv ====
package k16_cpu_pkg;

  import k16_isa_pkg::*;

  typedef enum logic [3:0] {
    FETCH,
    WAIT_INSTR,
    DECODE,
    STORE_RESULT,
    STORE_FLAGS,
    JUMP,
    MEM_ADDR,
    MEM_WAIT,
    MEM_STORE,
    HALTED
  } cpu_state_e;

  typedef enum logic [3:0] {
    EXEC_RESULT,
    EXEC_RESULT_CARRY,
    EXEC_FLAGS_ONLY,
    EXEC_JUMP,
    EXEC_LOAD,
    EXEC_STORE,
    EXEC_SET_CARRY,
    EXEC_HALT,
    EXEC_NONE
  } exec_kind_e;

  localparam reg_idx_t sp_idx   = 3'd6;
  localparam reg_idx_t pc_idx   = 3'd7;
  localparam word_t    reset_pc = 16'h0000;

endpackage

// ==== logic/k16_alu.sv ====
module k16_alu
  import k16_isa_pkg::*;
(
  input  word_t      operand_a,
  input  word_t      operand_b,
  input  logic       carry_in,
  input  logic [2:0] op_class,
  input  logic [2:0] func,
  output word_t      result,
  output logic       carry_out,
  output logic       zero_out,
  output logic       negative_out
);

  logic [16:0] sum;

  always_comb
  begin
    sum = 17'd0;
    result = operand_a;
    carry_out = carry_in;
    case (op_class)
      cls_arith:
      begin
        case (func)
          fn_add: sum = {1'b0, operand_a} + {1'b0, operand_b};
          fn_adc: sum = {1'b0, operand_a} + {1'b0, operand_b} + {16'd0, carry_in};
          // Bit 16 of a difference is the borrow
          fn_sub: sum = {1'b0, operand_a} - {1'b0, operand_b};
          fn_sbc: sum = {1'b0, operand_a} - {1'b0, operand_b} - {16'd0, carry_in};
          fn_and: sum = {1'b0, operand_a & operand_b};
          fn_or:  sum = {1'b0, operand_a | operand_b};
          fn_xor: sum = {1'b0, operand_a ^ operand_b};
          fn_not: sum = {1'b0, ~operand_a};
          default: sum = 17'd0;
        endcase
        result = sum[15:0];
        carry_out = sum[16];
      end
      cls_shift:
      begin
        case (func)
          fn_shr:
          begin
            result = {1'b0, operand_a[15:1]};
            carry_out = operand_a[0];
          end
          fn_shl:
          begin
            result = {operand_a[14:0], 1'b0};
            carry_out = operand_a[15];
          end
          fn_ashr:
          begin
            result = {operand_a[15], operand_a[15:1]};
            carry_out = operand_a[0];
          end
          fn_ror:
          begin
            result = {operand_a[0], operand_a[15:1]};
            carry_out = operand_a[0];
          end
          fn_rol:
          begin
            result = {operand_a[14:0], operand_a[15]};
            carry_out = operand_a[15];
          end
          default: result = operand_a;
        endcase
      end
      cls_byte:
      begin
        // Byte merges take the low byte of operand_b
        case (func)
          fn_ldl:  result = {operand_a[15:8], operand_b[7:0]};
          fn_ldh:  result = {operand_b[7:0], operand_a[7:0]};
          fn_ldlz: result = {8'h00, operand_b[7:0]};
          fn_ldhz: result = {operand_b[7:0], 8'h00};
          default: result = operand_a;
        endcase
      end
      default: result = operand_a;
    endcase
  end

  assign zero_out = (result == 16'h0000);
  assign negative_out = result[15];

endmodule

// ==== logic/k16_decoder.sv ====
module k16_decoder
  import k16_isa_pkg::*;
  import k16_cpu_pkg::*;
(
  input  k16_instr_u instr,
  input  logic       carry,
  input  logic       zero,
  input  logic       negative,
  output exec_kind_e exec_kind,
  output logic [2:0] alu_class,
  output logic [2:0] alu_func,
  output reg_idx_t   src_a,
  output reg_idx_t   src_b,
  output logic       use_imm,
  output word_t      imm,
  output reg_idx_t   dest,
  output logic       carry_value
);

  logic  taken;
  word_t offset7;
  word_t offset10;

  assign offset7 = {{9{instr.mem_form.offset[6]}}, instr.mem_form.offset};
  // JMP has no base field in bits 9..7, they extend the offset to 10 bits
  assign offset10 = {{6{instr.mem_form.base[2]}}, instr.mem_form.base, instr.mem_form.offset};

  always_comb
  begin
    case (instr.mem_form.dest)
      cond_cs: taken = carry;
      cond_cc: taken = !carry;
      cond_zs: taken = zero;
      cond_zc: taken = !zero;
      cond_ns: taken = negative;
      cond_nc: taken = !negative;
      // No overflow flag, so these never branch
      cond_os: taken = 1'b0;
      cond_oc: taken = 1'b0;
      default: taken = 1'b0;
    endcase
  end

  always_comb
  begin
    exec_kind = EXEC_NONE;
    alu_class = cls_arith;
    alu_func = fn_add;
    src_a = instr.reg_form.src_a;
    src_b = instr.reg_form.src_b;
    use_imm = 1'b0;
    imm = 16'h0000;
    dest = instr.reg_form.dest;
    carry_value = instr.reg_form.func[0];
    case (instr.reg_form.major)
      op_alu:
      begin
        alu_func = instr.reg_form.func[2:0];
        if (instr.reg_form.func[3:2] == 2'b00)
          exec_kind = EXEC_RESULT_CARRY;
        else if (instr.reg_form.func[3:2] == 2'b01)
          exec_kind = EXEC_RESULT;
        else if (instr.reg_form.func == sub_inc)
        begin
          exec_kind = EXEC_RESULT;
          alu_func = fn_add;
          use_imm = 1'b1;
          imm = 16'h0001;
        end
        else if (instr.reg_form.func == sub_dec)
        begin
          exec_kind = EXEC_RESULT;
          alu_func = fn_sub;
          use_imm = 1'b1;
          imm = 16'h0001;
        end
        else if (instr.reg_form.func == sub_cmp)
        begin
          exec_kind = EXEC_FLAGS_ONLY;
          alu_func = fn_sub;
        end
      end
      op_shift:
      begin
        alu_class = cls_shift;
        alu_func = instr.reg_form.func[2:0];
        if (!instr.reg_form.func[3] && instr.reg_form.func[2:0] <= fn_rol)
          exec_kind = EXEC_RESULT_CARRY;
        // CLC and SEC; bit 0 is the new carry
        else if (instr.reg_form.func[3:1] == 3'b100)
          exec_kind = EXEC_SET_CARRY;
      end
      op_branch:
      begin
        src_a = instr.mem_form.base;
        use_imm = 1'b1;
        imm = offset7;
        if (taken)
          exec_kind = EXEC_JUMP;
      end
      op_load_imm:
      begin
        exec_kind = EXEC_RESULT;
        alu_class = cls_byte;
        alu_func = {1'b0, instr.imm_form.mode};
        src_a = instr.imm_form.dest;
        use_imm = 1'b1;
        imm = {8'h00, instr.imm_form.imm};
      end
      op_jmp:
      begin
        src_a = instr.mem_form.dest;
        use_imm = 1'b1;
        imm = offset10;
        if (instr == halt_word)
          exec_kind = EXEC_HALT;
        else
          exec_kind = EXEC_JUMP;
      end
      op_jsr: exec_kind = EXEC_NONE;
      op_ld, op_sto:
      begin
        exec_kind = (instr.mem_form.major == op_ld) ? EXEC_LOAD : EXEC_STORE;
        src_a = instr.mem_form.base;
        use_imm = 1'b1;
        imm = offset7;
      end
      default: exec_kind = EXEC_NONE;
    endcase
  end

endmodule

// ==== logic/k16_control_unit.sv ====
module k16_control_unit
  import k16_isa_pkg::*;
  import k16_cpu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  word_t      data_in,
  input  exec_kind_e exec_kind,
  input  logic [2:0] alu_class,
  input  logic [2:0] alu_func,
  input  reg_idx_t   src_a,
  input  reg_idx_t   src_b,
  input  logic       use_imm,
  input  word_t      imm,
  input  reg_idx_t   dest,
  input  logic       carry_value,
  input  word_t      result,
  input  logic       carry_out,
  input  logic       zero_out,
  input  logic       negative_out,
  output k16_instr_u instr,
  output logic       carry,
  output logic       zero,
  output logic       negative,
  output word_t      operand_a,
  output word_t      operand_b,
  output logic [2:0] op_class,
  output logic [2:0] func,
  output word_t      address,
  output word_t      data_out,
  output logic       write,
  output logic       halted
);

  cpu_state_e state;
  exec_kind_e kind_q;
  reg_idx_t   dest_q;
  word_t      regs [8];

  // The fetched word is valid on data_in during DECODE
  assign instr = data_in;
  assign halted = (state == HALTED);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= FETCH;
      kind_q <= EXEC_NONE;
      write <= 1'b0;
      carry <= 1'b0;
      zero <= 1'b0;
      negative <= 1'b0;
      for (int i = 0; i < sp_idx; i++)
        regs[i] <= 16'h0000;
      regs[sp_idx] <= 16'h0000;
      regs[pc_idx] <= reset_pc;
    end
    else
    begin
      write <= 1'b0;
      case (state)
        FETCH:
        begin
          address <= regs[pc_idx];
          // ALU computes PC + 1 while the memory reads
          operand_a <= regs[pc_idx];
          operand_b <= 16'h0001;
          op_class <= cls_arith;
          func <= fn_add;
          state <= WAIT_INSTR;
        end
        WAIT_INSTR:
        begin
          regs[pc_idx] <= result;
          state <= DECODE;
        end
        DECODE:
        begin
          kind_q <= exec_kind;
          dest_q <= dest;
          op_class <= alu_class;
          func <= alu_func;
          operand_a <= regs[src_a];
          operand_b <= use_imm ? imm : regs[src_b];
          case (exec_kind)
            EXEC_RESULT, EXEC_RESULT_CARRY: state <= STORE_RESULT;
            EXEC_FLAGS_ONLY: state <= STORE_FLAGS;
            EXEC_JUMP: state <= JUMP;
            EXEC_LOAD, EXEC_STORE: state <= MEM_ADDR;
            EXEC_SET_CARRY:
            begin
              carry <= carry_value;
              state <= FETCH;
            end
            EXEC_HALT: state <= HALTED;
            default: state <= FETCH;
          endcase
        end
        STORE_RESULT:
        begin
          regs[dest_q] <= result;
          zero <= zero_out;
          negative <= negative_out;
          if (kind_q == EXEC_RESULT_CARRY)
            carry <= carry_out;
          state <= FETCH;
        end
        STORE_FLAGS:
        begin
          carry <= carry_out;
          zero <= zero_out;
          negative <= negative_out;
          state <= FETCH;
        end
        JUMP:
        begin
          regs[pc_idx] <= result;
          state <= FETCH;
        end
        MEM_ADDR:
        begin
          address <= result;
          if (kind_q == EXEC_STORE)
          begin
            write <= 1'b1;
            data_out <= regs[dest_q];
          end
          state <= MEM_WAIT;
        end
        MEM_WAIT:
        begin
          // Store holds write for a second edge, as the bus expects
          if (kind_q == EXEC_STORE)
          begin
            write <= 1'b1;
            state <= FETCH;
          end
          else
            state <= MEM_STORE;
        end
        MEM_STORE:
        begin
          regs[dest_q] <= data_in;
          zero <= (data_in == 16'h0000);
          negative <= data_in[15];
          state <= FETCH;
        end
        HALTED: state <= HALTED;
        default: state <= FETCH;
      endcase
    end
  end

endmodule

// ==== logic/k16_cpu.sv ====
module k16_cpu
  import k16_isa_pkg::*;
  import k16_cpu_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  word_t data_in,
  output word_t address,
  output word_t data_out,
  output logic  write,
  output logic  halted
);

  k16_instr_u instr;
  exec_kind_e exec_kind;
  logic [2:0] alu_class;
  logic [2:0] alu_func;
  logic [2:0] op_class;
  logic [2:0] func;
  reg_idx_t   src_a;
  reg_idx_t   src_b;
  reg_idx_t   dest;
  logic       use_imm;
  logic       carry_value;
  word_t      imm;
  word_t      operand_a;
  word_t      operand_b;
  word_t      result;
  logic       carry;
  logic       zero;
  logic       negative;
  logic       carry_out;
  logic       zero_out;
  logic       negative_out;

  k16_decoder u_decoder (
    .instr       (instr),
    .carry       (carry),
    .zero        (zero),
    .negative    (negative),
    .exec_kind   (exec_kind),
    .alu_class   (alu_class),
    .alu_func    (alu_func),
    .src_a       (src_a),
    .src_b       (src_b),
    .use_imm     (use_imm),
    .imm         (imm),
    .dest        (dest),
    .carry_value (carry_value)
  );

  k16_alu u_alu (
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .carry_in     (carry),
    .op_class     (op_class),
    .func         (func),
    .result       (result),
    .carry_out    (carry_out),
    .zero_out     (zero_out),
    .negative_out (negative_out)
  );

  k16_control_unit u_control_unit (
    .clk          (clk),
    .reset        (reset),
    .data_in      (data_in),
    .exec_kind    (exec_kind),
    .alu_class    (alu_class),
    .alu_func     (alu_func),
    .src_a        (src_a),
    .src_b        (src_b),
    .use_imm      (use_imm),
    .imm          (imm),
    .dest         (dest),
    .carry_value  (carry_value),
    .result       (result),
    .carry_out    (carry_out),
    .zero_out     (zero_out),
    .negative_out (negative_out),
    .instr        (instr),
    .carry        (carry),
    .zero         (zero),
    .negative     (negative),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .op_class     (op_class),
    .func         (func),
    .address      (address),
    .data_out     (data_out),
    .write        (write),
    .halted       (halted)
  );

endmodule

// ==== sim/k16_tb_memory.sv ====
module k16_tb_memory
  import k16_isa_pkg::*;
(
  input  logic  clk,
  input  word_t address,
  input  logic  write,
  input  word_t write_data,
  output word_t read_data
);

  word_t mem [4096];
  word_t read_q = 16'h0000;

  assign read_data = read_q;

  // Only the low 12 address bits select a word
  always @(posedge clk)
  begin
    read_q <= mem[address[11:0]];
    if (write)
      mem[address[11:0]] = write_data;
  end

endmodule

// ==== sim/k16_cpu_assertions.sv ====
module k16_cpu_assertions
  import k16_isa_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  write,
  input logic  halted,
  input word_t address
);

  int failure_count = 0;

  // Bus idle on the first cycle out of reset
  write_after_reset: assert property (@(posedge clk) reset |=> !write)
  else
  begin
    failure_count++;
    $error("write is high in the cycle after reset");
  end

  no_write_when_halted: assert property (
    @(posedge clk) disable iff (reset) halted |-> !$rose(write))
  else
  begin
    failure_count++;
    $error("write rose while the core is halted");
  end

  address_held: assert property (
    @(posedge clk) disable iff (reset) halted |=> $stable(address))
  else
  begin
    failure_count++;
    $error("address changed while the core is halted");
  end

endmodule

bind k16_control_unit k16_cpu_assertions bus_checks (
  .clk     (clk),
  .reset   (reset),
  .write   (write),
  .halted  (halted),
  .address (address)
);

// ==== sim/k16_cpu_tb.sv ====
module k16_cpu_tb
  import k16_isa_pkg::*;
();

  localparam int timeout_cycles = 3000;
  localparam logic [11:0] data_base = 12'h800;
  localparam word_t marker = 16'h5a5a;
  localparam word_t poison_word = 16'hdead;
  localparam word_t clc_word = {op_shift, 9'd0, 4'b1000};
  localparam word_t sec_word = {op_shift, 9'd0, 4'b1001};

  logic        clk;
  logic        reset;
  word_t       data_in;
  word_t       address;
  word_t       data_out;
  logic        write;
  logic        halted;
  int          error_count;
  int          bound_failures;
  int          cycle_count;
  int          slot;
  logic [31:0] rng_state;
  word_t       program_q [$];
  logic [11:0] check_addr_q [$];
  word_t       check_data_q [$];

  k16_cpu DUT (
    .clk      (clk),
    .reset    (reset),
    .data_in  (data_in),
    .address  (address),
    .data_out (data_out),
    .write    (write),
    .halted   (halted)
  );

  k16_tb_memory memory (
    .clk        (clk),
    .address    (address),
    .write      (write),
    .write_data (data_out),
    .read_data  (data_in)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t random_word();
    rng_state = xorshift(rng_state);
    return rng_state[15:0];
  endfunction

  function automatic word_t fill_pattern(input logic [11:0] addr);
    return {4'he, addr};
  endfunction

  function automatic word_t reg_op(input logic [2:0] major, input logic [3:0] fn,
                                   input logic [2:0] d, input logic [2:0] a,
                                   input logic [2:0] b);
    return {major, d, a, b, fn};
  endfunction

  function automatic word_t mem_op(input logic [2:0] major, input logic [2:0] d,
                                   input logic [2:0] base, input logic [6:0] offset);
    return {major, d, base, offset};
  endfunction

  function automatic word_t imm_op(input logic [1:0] mode, input logic [2:0] d,
                                   input logic [7:0] value);
    return {op_load_imm, d, mode, value};
  endfunction

  task automatic emit(input word_t w);
    program_q.push_back(w);
  endtask

  task automatic expect_word(input logic [11:0] addr, input word_t value);
    check_addr_q.push_back(addr);
    check_data_q.push_back(value);
  endtask

  task automatic load_reg(input logic [2:0] d, input word_t value);
    emit(imm_op(fn_ldlz[1:0], d, value[7:0]));
    emit(imm_op(fn_ldh[1:0], d, value[15:8]));
  endtask

  // R5 points at the result area, one slot per store
  task automatic store_check(input logic [2:0] r, input word_t expected);
    emit(mem_op(op_sto, r, 3'd5, 7'(slot)));
    expect_word(data_base + 12'(slot), expected);
    slot++;
  endtask

  task automatic start_test();
    program_q.delete();
    check_addr_q.delete();
    check_data_q.delete();
    slot = 0;
    load_reg(3'd5, {4'h0, data_base});
  endtask

  task automatic reset_and_load();
    @(posedge clk);
    reset <= 1'b1;
    for (int i = 0; i < 4096; i++)
      memory.mem[12'(i)] = fill_pattern(12'(i));
    foreach (program_q[i])
      memory.mem[12'(i)] = program_q[i];
  endtask

  task automatic run_to_halt();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    while (!halted)
      @(negedge clk);
  endtask

  task automatic check_memory(input string name);
    word_t got;
    foreach (check_addr_q[i])
    begin
      got = memory.mem[check_addr_q[i]];
      assert (got == check_data_q[i])
      else
      begin
        error_count++;
        $display("** Error at %0t: %s, word at 0x%03h is 0x%04h, expected 0x%04h",
                 $time, name, check_addr_q[i], got, check_data_q[i]);
      end
    end
  endtask

  task automatic alu_test();
    word_t a;
    word_t b;
    a = random_word();
    b = random_word();
    start_test();
    load_reg(3'd1, a);
    load_reg(3'd2, b);
    emit(reg_op(op_alu, {1'b0, fn_add}, 3'd3, 3'd1, 3'd2));
    store_check(3'd3, a + b);
    emit(sec_word);
    emit(reg_op(op_alu, {1'b0, fn_adc}, 3'd3, 3'd1, 3'd2));
    store_check(3'd3, a + b + 16'd1);
    emit(clc_word);
    emit(reg_op(op_alu, {1'b0, fn_adc}, 3'd3, 3'd1, 3'd2));
    store_check(3'd3, a + b);
    emit(reg_op(op_alu, {1'b0, fn_sub}, 3'd3, 3'd1, 3'd2));
    store_check(3'd3, a - b);
    emit(sec_word);
    emit(reg_op(op_alu, {1'b0, fn_sbc}, 3'd3, 3'd1, 3'd2));
    store_check(3'd3, a - b - 16'd1);
    emit(clc_word);
    emit(reg_op(op_alu, {1'b0, fn_sbc}, 3'd3, 3'd1, 3'd2));
    store_check(3'd3, a - b);
    emit(reg_op(op_alu, {1'b0, fn_and}, 3'd3, 3'd1, 3'd2));
    store_check(3'd3, a & b);
    emit(reg_op(op_alu, {1'b0, fn_or}, 3'd3, 3'd1, 3'd2));
    store_check(3'd3, a | b);
    emit(reg_op(op_alu, {1'b0, fn_xor}, 3'd3, 3'd1, 3'd2));
    store_check(3'd3, a ^ b);
    emit(reg_op(op_alu, {1'b0, fn_not}, 3'd3, 3'd1, 3'd0));
    store_check(3'd3, ~a);
    emit(halt_word);
    reset_and_load();
    run_to_halt();
    check_memory("ALU");
  endtask

  task automatic shift_test();
    word_t      v;
    word_t      r;
    logic       c;
    logic [2:0] fn;
    start_test();
    for (int f = 0; f < 5; f++)
    begin
      fn = 3'(f);
      v = random_word();
      r = v;
      c = 1'b0;
      case (fn)
        fn_shr:
        begin
          r = v >> 1;
          c = v[0];
        end
        fn_shl:
        begin
          r = v << 1;
          c = v[15];
        end
        fn_ashr:
        begin
          r = {v[15], v[15:1]};
          c = v[0];
        end
        fn_ror:
        begin
          r = {v[0], v[15:1]};
          c = v[0];
        end
        default:
        begin
          r = {v[14:0], v[15]};
          c = v[15];
        end
      endcase
      load_reg(3'd1, v);
      emit(reg_op(op_shift, {1'b0, fn}, 3'd3, 3'd1, 3'd0));
      store_check(3'd3, r);
      // R0 stays zero, so the sum is the carry
      emit(reg_op(op_alu, {1'b0, fn_adc}, 3'd4, 3'd0, 3'd0));
      store_check(3'd4, {15'd0, c});
    end
    emit(halt_word);
    reset_and_load();
    run_to_halt();
    check_memory("shift");
  endtask

  task automatic merge_test();
    word_t      a;
    logic [7:0] b;
    a = random_word();
    b = 8'(random_word());
    start_test();
    load_reg(3'd3, a);
    emit(imm_op(fn_ldl[1:0], 3'd3, b));
    store_check(3'd3, {a[15:8], b});
    load_reg(3'd3, a);
    emit(imm_op(fn_ldh[1:0], 3'd3, b));
    store_check(3'd3, {b, a[7:0]});
    emit(imm_op(fn_ldlz[1:0], 3'd3, b));
    store_check(3'd3, {8'h00, b});
    emit(imm_op(fn_ldhz[1:0], 3'd3, b));
    store_check(3'd3, {b, 8'h00});
    load_reg(3'd1, 16'hffff);
    emit(reg_op(op_alu, sub_inc, 3'd3, 3'd1, 3'd0));
    store_check(3'd3, 16'h0000);
    load_reg(3'd1, 16'h0000);
    emit(reg_op(op_alu, sub_dec, 3'd3, 3'd1, 3'd0));
    store_check(3'd3, 16'hffff);
    load_reg(3'd1, a);
    emit(reg_op(op_alu, sub_inc, 3'd3, 3'd1, 3'd0));
    store_check(3'd3, a + 16'd1);
    emit(reg_op(op_alu, sub_dec, 3'd3, 3'd1, 3'd0));
    store_check(3'd3, a - 16'd1);
    emit(halt_word);
    reset_and_load();
    run_to_halt();
    check_memory("byte merge and INC/DEC");
  endtask

  task automatic branch_test();
    word_t a [3];
    word_t b [3];
    word_t diff;
    logic  c;
    logic  z;
    logic  n;
    logic  taken;
    a[0] = random_word();
    b[0] = random_word();
    a[1] = a[0];
    b[1] = a[0];
    a[2] = 16'h0001;
    b[2] = 16'h8000;
    start_test();
    load_reg(3'd4, marker);
    for (int p = 0; p < 3; p++)
    begin
      diff = a[p] - b[p];
      c = a[p] < b[p];
      z = a[p] == b[p];
      n = diff[15];
      load_reg(3'd1, a[p]);
      load_reg(3'd2, b[p]);
      emit(reg_op(op_alu, sub_cmp, 3'd0, 3'd1, 3'd2));
      for (int k = 0; k < 8; k++)
      begin
        case (3'(k))
          cond_cs: taken = c;
          cond_cc: taken = !c;
          cond_zs: taken = z;
          cond_zc: taken = !z;
          cond_ns: taken = n;
          cond_nc: taken = !n;
          default: taken = 1'b0;
        endcase
        // A taken branch skips the marker store
        emit(mem_op(op_branch, 3'(k), 3'd7, 7'd1));
        store_check(3'd4, taken ? fill_pattern(data_base + 12'(slot)) : marker);
      end
    end
    emit(halt_word);
    reset_and_load();
    run_to_halt();
    check_memory("branch");
  endtask

  task automatic memory_test();
    word_t d1;
    word_t d2;
    int    target;
    d1 = random_word();
    d2 = random_word();
    start_test();
    load_reg(3'd2, 16'h0830);
    emit(mem_op(op_ld, 3'd1, 3'd2, 7'd16));
    emit(mem_op(op_ld, 3'd3, 3'd2, 7'h70));
    emit(mem_op(op_sto, 3'd1, 3'd2, 7'h78));
    emit(mem_op(op_sto, 3'd3, 3'd2, 7'd5));
    expect_word(12'h828, d1);
    expect_word(12'h835, d2);
    load_reg(3'd4, poison_word);
    emit({op_jmp, 3'd7, 10'd1});
    store_check(3'd4, fill_pattern(data_base + 12'(slot)));
    // Target sits past the load pair, the JMP and the poisoned store
    target = program_q.size() + 4;
    load_reg(3'd2, 16'(target));
    emit({op_jmp, 3'd2, 10'd0});
    store_check(3'd4, fill_pattern(data_base + 12'(slot)));
    store_check(3'd1, d1);
    emit(halt_word);
    reset_and_load();
    memory.mem[12'h840] = d1;
    memory.mem[12'h820] = d2;
    run_to_halt();
    check_memory("LD/STO/JMP");
  endtask

  task automatic halt_test();
    word_t v;
    word_t held_address;
    v = random_word();
    start_test();
    load_reg(3'd1, v);
    store_check(3'd1, v);
    emit(halt_word);
    store_check(3'd1, fill_pattern(data_base + 12'(slot)));
    reset_and_load();
    run_to_halt();
    held_address = address;
    repeat (20)
    begin
      @(negedge clk);
      assert (halted && !write && address == held_address)
      else
      begin
        error_count++;
        $display("** Error at %0t: halted %b, write %b, address 0x%04h after HLT",
                 $time, halted, write, address);
      end
    end
    check_memory("HLT");
  endtask

  initial
  begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the DUT did not finish all tests within %0d clock cycles",
             timeout_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    reset = 1'b1;
    error_count = 0;
    rng_state = 32'hff49;
    alu_test();
    shift_test();
    merge_test();
    branch_test();
    memory_test();
    halt_test();
    bound_failures = DUT.u_control_unit.bus_checks.failure_count;
    $display("Errors: %0d in value checks, %0d in bound assertions",
             error_count, bound_failures);
    if (error_count == 0 && bound_failures == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== project.f ====
logic/k16_isa_pkg.sv
logic/k16_cpu_pkg.sv
logic/k16_alu.sv
logic/k16_decoder.sv
logic/k16_control_unit.sv
logic/k16_cpu.sv
sim/k16_tb_memory.sv
sim/k16_cpu_assertions.sv
sim/k16_cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module k16_cpu_tb -f project.f -o k16_cpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/k16_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0
